/* verilog.f */
verilog/riscv_isa_pkg.sv
verilog/ex_ctrl_pkg.sv
verilog/ex_control.sv
verilog/alu.sv
verilog/imm_gen.sv
verilog/regfile.sv
verilog/ex_pipeline.sv
test/ex_pipeline_props.sv
test/ex_pipeline_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds and runs the testbench; exit status follows the simulation result
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -j 0 -f verilog.f \
    --top-module ex_pipeline_tb -o ex_pipeline_sim \
    && ./obj_dir/ex_pipeline_sim \
    || exit 1

/* test/ex_pipeline_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module ex_pipeline_tb;

    localparam int PROG_LEN = 160;
    localparam int CLK_PERIOD = 100;
    localparam int WATCHDOG_NS = (20 * PROG_LEN + 8) * CLK_PERIOD;
    localparam logic [6:0] OP_R = 7'b0110011;
    localparam logic [6:0] OP_I = 7'b0010011;
    localparam logic [6:0] OP_BR = 7'b1100011;
    localparam logic [6:0] OP_LUI = 7'b0110111;
    localparam logic [6:0] OP_AUIPC = 7'b0010111;
    localparam logic [6:0] OP_SYS = 7'b1110011;
    localparam logic [11:0] SCRATCH = 12'h51E;

    logic        clk;
    logic        rst;
    logic        in_valid;
    logic [31:0] in_inst;
    logic [31:0] in_pc;
    logic        in_pred_taken;
    logic        out_ready;
    logic        in_ready;
    logic        out_valid;
    logic [31:0] out_pc;
    logic [4:0]  out_rd;
    logic        out_wen;
    logic [31:0] out_value;
    logic        redirect_valid;
    logic [31:0] redirect_pc;
    logic [31:0] csr_value;

    logic [31:0] prog [0:PROG_LEN-1];
    logic        pred_mem [0:PROG_LEN-1];
    logic [31:0] ref_regs [0:31];
    logic [31:0] ref_csr;
    logic [31:0] ref_pc;
    logic [31:0] redir_q [$];
    logic        started;
    logic        done;

    // Front-end state
    logic [31:0] fe_pc;
    logic [31:0] fe_next;
    logic        fe_new;
    logic        took_xfer;
    logic        took_redir;
    logic [31:0] took_rpc;

    // Compare process state
    logic [31:0] exp_inst;
    logic [4:0]  exp_rd;
    logic        exp_wen;
    logic [31:0] exp_value;
    logic [31:0] exp_next;
    logic [31:0] exp_redir;

    ex_pipeline UUT (
        .clk            (clk),
        .rst            (rst),
        .in_valid       (in_valid),
        .in_inst        (in_inst),
        .in_pc          (in_pc),
        .in_pred_taken  (in_pred_taken),
        .out_ready      (out_ready),
        .in_ready       (in_ready),
        .out_valid      (out_valid),
        .out_pc         (out_pc),
        .out_rd         (out_rd),
        .out_wen        (out_wen),
        .out_value      (out_value),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .csr_value      (csr_value)
    );

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("Test failures found");
        $fatal(1);
    endtask

    function automatic logic [31:0] encode_r(input logic alt, input logic [2:0] f3,
                                             input logic [4:0] rd, input logic [4:0] rs1,
                                             input logic [4:0] rs2);
        return {1'b0, alt, 5'b0, rs2, rs1, f3, rd, OP_R};
    endfunction

    function automatic logic [31:0] encode_i(input logic [11:0] imm, input logic [4:0] rs1,
                                             input logic [2:0] f3, input logic [4:0] rd,
                                             input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] branch_offset(input logic [31:0] inst);
        return {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    endfunction

    function automatic logic [31:0] random_inst();
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [2:0]  f3;
        logic [12:0] off;
        logic [11:0] imm;
        logic        alt;
        int          kind;
        kind = $urandom % 10;
        rd = 5'($urandom % 8);
        rs1 = 5'($urandom % 8);
        rs2 = 5'($urandom % 8);
        f3 = 3'($urandom % 8);
        alt = 1'($urandom % 2);
        imm = 12'($urandom);
        if (kind < 3) begin
            return encode_r((f3 == 3'd0 || f3 == 3'd5) ? alt : 1'b0, f3, rd, rs1, rs2);
        end else if (kind < 6) begin
            if (f3 == 3'd1) begin
                imm = {7'b0, imm[4:0]};
            end else if (f3 == 3'd5) begin
                imm = {1'b0, alt, 5'b0, imm[4:0]};
            end
            return encode_i(imm, rs1, f3, rd, OP_I);
        end else if (kind == 6) begin
            return {20'($urandom), rd, OP_LUI};
        end else if (kind == 7) begin
            return {20'($urandom), rd, OP_AUIPC};
        end else if (kind == 8) begin
            // Forward targets only, so every program ends
            off = 13'(8 + 4 * ($urandom % 7));
            case ($urandom % 6)
                0: f3 = 3'd0;
                1: f3 = 3'd1;
                2: f3 = 3'd4;
                3: f3 = 3'd5;
                4: f3 = 3'd6;
                default: f3 = 3'd7;
            endcase
            return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OP_BR};
        end
        return encode_i(alt ? SCRATCH : 12'h340, 5'($urandom), alt ? 3'd1 : 3'd5, rd, OP_SYS);
    endfunction

    task automatic build_program();
        // Dependency chains through MEM, WB and the register file bypass
        prog[0] = encode_i(12'd5, 5'd0, 3'd0, 5'd1, OP_I);
        prog[1] = encode_i(12'd3, 5'd1, 3'd0, 5'd2, OP_I);
        prog[2] = encode_r(1'b0, 3'd0, 5'd3, 5'd1, 5'd2);
        prog[3] = encode_r(1'b1, 3'd0, 5'd4, 5'd3, 5'd1);
        prog[4] = encode_i(12'd1, 5'd0, 3'd0, 5'd5, OP_I);
        prog[5] = encode_i(12'd2, 5'd0, 3'd0, 5'd5, OP_I);
        prog[6] = encode_r(1'b0, 3'd0, 5'd6, 5'd5, 5'd5);
        prog[7] = {20'hFFFFF, 5'd7, OP_LUI};
        prog[8] = encode_r(1'b0, 3'd2, 5'd2, 5'd7, 5'd6);
        prog[9] = encode_r(1'b0, 3'd3, 5'd3, 5'd7, 5'd6);
        prog[10] = encode_i(SCRATCH, 5'd6, 3'd1, 5'd0, OP_SYS);
        prog[11] = encode_i(SCRATCH, 5'd13, 3'd5, 5'd0, OP_SYS);
        prog[12] = encode_i(12'h340, 5'd1, 3'd1, 5'd0, OP_SYS);
        for (int i = 13; i < PROG_LEN; i++) begin
            prog[i] = random_inst();
        end
    endtask

    function automatic logic [31:0] arith(input logic [2:0] f3, input logic alt,
                                          input logic [31:0] a, input logic [31:0] b);
        case (f3)
            3'd0: return alt ? a - b : a + b;
            3'd1: return a << b[4:0];
            3'd2: return {31'b0, $signed(a) < $signed(b)};
            3'd3: return {31'b0, a < b};
            3'd4: return a ^ b;
            3'd5: return alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'd6: return a | b;
            default: return a & b;
        endcase
    endfunction

    // Architectural model stepping one instruction per call
    function automatic void reference_step(input logic [31:0] inst, input logic [31:0] pc,
                                           output logic [4:0] rd, output logic wen,
                                           output logic [31:0] value,
                                           output logic [31:0] next_pc);
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] immi;
        logic [2:0]  f3;
        logic        wr;
        logic        taken;
        a = ref_regs[inst[19:15]];
        b = ref_regs[inst[24:20]];
        immi = {{20{inst[31]}}, inst[31:20]};
        f3 = inst[14:12];
        rd = inst[11:7];
        wr = 1'b0;
        value = 32'd0;
        next_pc = pc + 32'd4;
        case (inst[6:0])
            OP_R: begin
                wr = 1'b1;
                value = arith(f3, inst[30], a, b);
            end
            OP_I: begin
                wr = 1'b1;
                value = arith(f3, f3 == 3'd5 && inst[30], a, immi);
            end
            OP_LUI: begin
                wr = 1'b1;
                value = {inst[31:12], 12'b0};
            end
            OP_AUIPC: begin
                wr = 1'b1;
                value = pc + {inst[31:12], 12'b0};
            end
            OP_BR: begin
                case (f3)
                    3'd0: taken = a == b;
                    3'd1: taken = a != b;
                    3'd4: taken = $signed(a) < $signed(b);
                    3'd5: taken = $signed(a) >= $signed(b);
                    3'd6: taken = a < b;
                    default: taken = a >= b;
                endcase
                if (taken) begin
                    next_pc = pc + branch_offset(inst);
                end
            end
            default: begin
                if (inst[31:20] == SCRATCH && f3 == 3'd1) begin
                    ref_csr = a;
                end else if (inst[31:20] == SCRATCH && f3 == 3'd5) begin
                    ref_csr = {27'b0, inst[19:15]};
                end
            end
        endcase
        wen = wr && rd != 5'd0;
        if (wen) begin
            ref_regs[rd] = value;
        end
    endfunction

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(WATCHDOG_NS);
        report_failure("Watchdog expired before the program finished retiring");
    end

    initial begin
        void'($urandom(77290));
        rst = 1'b1;
        in_valid = 1'b0;
        in_inst = 32'h0000_0013;
        in_pc = 32'd0;
        in_pred_taken = 1'b0;
        out_ready = 1'b0;
        started = 1'b0;
        done = 1'b0;
        fe_pc = 32'd0;
        fe_next = 32'd4;
        fe_new = 1'b1;
        took_xfer = 1'b0;
        took_redir = 1'b0;
        took_rpc = 32'd0;
        ref_csr = 32'd0;
        ref_pc = 32'd0;
        for (int i = 0; i < 32; i++) begin
            ref_regs[i] = 32'd0;
        end
        for (int i = 0; i < PROG_LEN; i++) begin
            pred_mem[i] = 1'b0;
        end
        build_program();
        repeat (8) @(negedge clk);
        rst = 1'b0;
        @(posedge clk);
        started = 1'b1;
        wait (done);
        repeat (12) @(negedge clk);
        if (redir_q.size() == 0 && csr_value == ref_csr) begin
            $display("All tests passed!");
            $finish;
        end else begin
            report_failure("Redirect without a mispredict or CSR differs at the end of the run");
        end
    end

    // Front-end model driving on the falling edge
    always @(negedge clk) begin
        if (started) begin
            if (took_redir) begin
                fe_pc = took_rpc;
                fe_new = 1'b1;
            end else if (took_xfer) begin
                fe_pc = fe_next;
                fe_new = 1'b1;
            end
            if (fe_pc < PROG_LEN * 4) begin
                in_valid = 1'b1;
                in_inst = prog[fe_pc >> 2];
                in_pc = fe_pc;
                if (fe_new) begin
                    in_pred_taken = (in_inst[6:0] == OP_BR) ? 1'($urandom % 2) : 1'b0;
                end
                fe_next = in_pred_taken ? fe_pc + branch_offset(in_inst) : fe_pc + 32'd4;
            end else begin
                in_valid = 1'b0;
                in_inst = 32'h0000_0013;
            end
            fe_new = 1'b0;
            out_ready = ($urandom % 4) != 0;
            #1;
            took_xfer = in_valid && in_ready;
            took_redir = redirect_valid;
            took_rpc = redirect_pc;
            if (redirect_valid) begin
                redir_q.push_back(redirect_pc);
            end
            if (took_xfer && !redirect_valid) begin
                pred_mem[fe_pc >> 2] = in_pred_taken;
            end
        end
    end

    // Retire compare
    always @(negedge clk) begin
        if (started) begin
            #2;
            if (out_valid && out_ready) begin
                assert (ref_pc < PROG_LEN * 4)
                else report_failure("Instruction retired after the program ended");
                assert (csr_value == ref_csr)
                else report_failure($sformatf("Mismatch csr_value: got %h expected %h",
                                              csr_value, ref_csr));
                exp_inst = prog[ref_pc >> 2];
                reference_step(exp_inst, ref_pc, exp_rd, exp_wen, exp_value, exp_next);
                assert (out_pc == ref_pc)
                else report_failure($sformatf("Mismatch out_pc: got %h expected %h",
                                              out_pc, ref_pc));
                assert (out_rd == exp_rd)
                else report_failure($sformatf("Mismatch out_rd: got %h expected %h",
                                              out_rd, exp_rd));
                assert (out_wen == exp_wen)
                else report_failure($sformatf("Mismatch out_wen: got %h expected %h",
                                              out_wen, exp_wen));
                assert (!exp_wen || out_value == exp_value)
                else report_failure($sformatf("Mismatch out_value: got %h expected %h",
                                              out_value, exp_value));
                if (exp_inst[6:0] == OP_BR &&
                    (exp_next != ref_pc + 32'd4) != pred_mem[ref_pc >> 2]) begin
                    assert (redir_q.size() > 0)
                    else report_failure("Mispredicted branch retired without a redirect");
                    exp_redir = redir_q.pop_front();
                    assert (exp_redir == exp_next)
                    else report_failure($sformatf("Mismatch redirect_pc: got %h expected %h",
                                                  exp_redir, exp_next));
                end
                ref_pc = exp_next;
                if (ref_pc >= PROG_LEN * 4) begin
                    done = 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* test/ex_pipeline_props.sv */
`timescale 1ns/100ps
`default_nettype none

module ex_pipeline_props (
    input wire logic        clk,
    input wire logic        rst,
    input wire logic        in_ready,
    input wire logic        out_valid,
    input wire logic        out_ready,
    input wire logic [31:0] out_pc,
    input wire logic [4:0]  out_rd,
    input wire logic        out_wen,
    input wire logic [31:0] out_value,
    input wire logic        redirect_valid,
    input wire logic [31:0] ex_inst
);

    assert property (@(posedge clk) $past(rst) |-> !out_valid && !redirect_valid)
    else $error("out_valid or redirect_valid high right after reset");

    // Retire outputs hold under back-pressure
    assert property (@(posedge clk) disable iff (rst)
        out_valid && !out_ready |=> out_valid && $stable(out_pc) && $stable(out_rd) &&
                                    $stable(out_wen) && $stable(out_value))
    else $error("Retire outputs changed while stalled");

    // A stall holds the EX slot and the retiring instruction
    assert property (@(posedge clk) disable iff (rst)
        !in_ready |=> out_valid && $stable(ex_inst))
    else $error("Pipeline moved while in_ready was low");

    assert property (@(posedge clk) disable iff (rst) redirect_valid |=> !redirect_valid)
    else $error("redirect_valid high for two cycles");

endmodule

bind ex_pipeline ex_pipeline_props u_props (.*);

`default_nettype wire

/* verilog/ex_pipeline.sv */
`timescale 1ns/100ps
`default_nettype none

module ex_pipeline import riscv_isa_pkg::*, ex_ctrl_pkg::*; #(
    parameter logic [11:0] CSR_ADDR = 12'h51E
) (
    input  logic            clk,
    input  logic            rst,
    input  logic            in_valid,
    input  logic [31:0]     in_inst,
    input  logic [XLEN-1:0] in_pc,
    input  logic            in_pred_taken,
    input  logic            out_ready,
    output logic            in_ready,
    output logic            out_valid,
    output logic [XLEN-1:0] out_pc,
    output logic [4:0]      out_rd,
    output logic            out_wen,
    output logic [XLEN-1:0] out_value,
    output logic            redirect_valid,
    output logic [XLEN-1:0] redirect_pc,
    output logic [XLEN-1:0] csr_value
);

    logic            advance;
    logic            retire;
    logic            take_in;
    logic [XLEN-1:0] id_rs1;
    logic [XLEN-1:0] id_rs2;
    logic [XLEN-1:0] id_imm;

    logic            ex_valid;
    logic [31:0]     ex_inst;
    logic [XLEN-1:0] ex_pc;
    logic            ex_pred;
    logic [XLEN-1:0] ex_rs1;
    logic [XLEN-1:0] ex_rs2;
    logic [XLEN-1:0] ex_imm;

    logic            mem_valid;
    logic [31:0]     mem_inst;
    logic [XLEN-1:0] mem_pc;
    logic [XLEN-1:0] mem_result;
    logic            mem_csr_we;

    logic            wb_valid;
    logic [31:0]     wb_inst;
    logic [XLEN-1:0] wb_pc;
    logic [XLEN-1:0] wb_result;
    logic            wb_csr_we;

    logic            brun;
    logic            breq;
    logic            brlt;
    fwd_sel_e        fwda;
    fwd_sel_e        fwdb;
    a_sel_e          asel;
    b_sel_e          bsel;
    csr_src_e        csr_src;
    logic            csr_en;
    logic            br_mispred;
    logic            flush;
    alu_op_e         alusel;
    logic [XLEN-1:0] rs1_fwd;
    logic [XLEN-1:0] rs2_fwd;
    logic [XLEN-1:0] op_a;
    logic [XLEN-1:0] op_b;
    logic [XLEN-1:0] alu_result;
    logic [XLEN-1:0] ex_result;
    logic [XLEN-1:0] csr_q;

    // Whole pipeline moves together, held only by a stuck WB slot
    assign advance = !wb_valid || out_ready;
    assign in_ready = advance;
    assign retire = wb_valid && out_ready;
    // Wrong-path instruction behind a mispredict is dropped
    assign take_in = in_valid && !(ex_valid && flush);

    regfile u_regfile (
        .clk    (clk),
        .rst    (rst),
        .raddr1 (inst_rs1(in_inst)),
        .raddr2 (inst_rs2(in_inst)),
        .waddr  (out_rd),
        .wen    (retire && out_wen),
        .wdata  (wb_result),
        .rdata1 (id_rs1),
        .rdata2 (id_rs2)
    );

    imm_gen u_imm_gen (
        .inst (in_inst),
        .imm  (id_imm)
    );

    always_ff @(posedge clk) begin
        if (rst) begin
            ex_valid <= 1'b0;
            ex_inst  <= NOP_INST;
        end else if (advance) begin
            ex_valid <= take_in;
            ex_inst  <= take_in ? in_inst : NOP_INST;
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            ex_pc   <= in_pc;
            ex_pred <= in_pred_taken;
            ex_rs1  <= id_rs1;
            ex_rs2  <= id_rs2;
            ex_imm  <= id_imm;
        end
    end

    ex_control #(
        .CSR_ADDR (CSR_ADDR)
    ) u_ex_control (
        .inst       (ex_inst),
        .mem_inst   (mem_inst),
        .wb_inst    (wb_inst),
        .breq       (breq),
        .brlt       (brlt),
        .br_taken   (ex_pred),
        .brun       (brun),
        .fwda       (fwda),
        .fwdb       (fwdb),
        .asel       (asel),
        .bsel       (bsel),
        .csr_src    (csr_src),
        .csr_en     (csr_en),
        .br_mispred (br_mispred),
        .br_suc     (),
        .flush      (flush),
        .alusel     (alusel)
    );

    always_comb begin
        case (fwda)
            FWD_MEM: rs1_fwd = mem_result;
            FWD_WB:  rs1_fwd = wb_result;
            default: rs1_fwd = ex_rs1;
        endcase
        case (fwdb)
            FWD_MEM: rs2_fwd = mem_result;
            FWD_WB:  rs2_fwd = wb_result;
            default: rs2_fwd = ex_rs2;
        endcase
    end

    assign op_a = (asel == A_PC) ? ex_pc : rs1_fwd;
    assign op_b = (bsel == B_IMM) ? ex_imm : rs2_fwd;

    alu u_alu (
        .a      (op_a),
        .b      (op_b),
        .op     (alusel),
        .brun   (brun),
        .result (alu_result),
        .breq   (),
        .brlt   ()
    );

    // Branch compare on the forwarded registers, PC and imm go to u_alu
    alu u_cmp (
        .a      (rs1_fwd),
        .b      (rs2_fwd),
        .op     (ALU_SUB),
        .brun   (brun),
        .result (),
        .breq   (breq),
        .brlt   (brlt)
    );

    // CSR ops carry their write data down the pipe in the result slot
    assign ex_result = !csr_en ? alu_result :
                       (csr_src == CSR_IMM) ? ex_imm : rs1_fwd;

    assign redirect_valid = ex_valid && br_mispred && advance;
    assign redirect_pc = alu_result;

    always_ff @(posedge clk) begin
        if (rst) begin
            mem_valid  <= 1'b0;
            mem_inst   <= NOP_INST;
            mem_csr_we <= 1'b0;
            wb_valid   <= 1'b0;
            wb_inst    <= NOP_INST;
            wb_csr_we  <= 1'b0;
        end else if (advance) begin
            mem_valid  <= ex_valid;
            mem_inst   <= ex_inst;
            mem_csr_we <= ex_valid && csr_en;
            wb_valid   <= mem_valid;
            wb_inst    <= mem_inst;
            wb_csr_we  <= mem_csr_we;
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            mem_pc     <= ex_pc;
            mem_result <= ex_result;
            wb_pc      <= mem_pc;
            wb_result  <= mem_result;
        end
    end

    // Scratch CSR, updated at retire
    always_ff @(posedge clk) begin
        if (rst) begin
            csr_q <= '0;
        end else if (retire && wb_csr_we) begin
            csr_q <= wb_result;
        end
    end

    assign csr_value = csr_q;

    assign out_valid = wb_valid;
    assign out_pc    = wb_pc;
    assign out_rd    = inst_rd(wb_inst);
    assign out_wen   = writes_rd(wb_inst);
    assign out_value = wb_result;

endmodule

`default_nettype wire

/* verilog/regfile.sv */
`timescale 1ns/100ps
`default_nettype none

module regfile import riscv_isa_pkg::*; (
    input  logic            clk,
    input  logic            rst,
    input  logic [4:0]      raddr1,
    input  logic [4:0]      raddr2,
    input  logic [4:0]      waddr,
    input  logic            wen,
    input  logic [XLEN-1:0] wdata,
    output logic [XLEN-1:0] rdata1,
    output logic [XLEN-1:0] rdata2
);

    logic [XLEN-1:0] regs [1:31];

    // x0 reads zero, a same-cycle write is bypassed
    function automatic logic [XLEN-1:0] read_port(input logic [4:0] addr);
        if (addr == 5'd0) begin
            return '0;
        end else if (wen && waddr == addr) begin
            return wdata;
        end
        return regs[addr];
    endfunction

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wen && waddr != 5'd0) begin
            regs[waddr] <= wdata;
        end
    end

    assign rdata1 = read_port(raddr1);
    assign rdata2 = read_port(raddr2);

endmodule

`default_nettype wire

/* verilog/imm_gen.sv */
`timescale 1ns/100ps
`default_nettype none

module imm_gen import riscv_isa_pkg::*; (
    input  logic [31:0] inst,
    output logic [31:0] imm
);

    always_comb begin
        case (inst_opcode(inst))
            OPC_ARI_ITYPE, OPC_LOAD, OPC_JALR: begin
                imm = {{20{inst[31]}}, inst[31:20]};
            end
            OPC_STORE: begin
                imm = {{20{inst[31]}}, inst[31:25], inst[11:7]};
            end
            OPC_BRANCH: begin
                imm = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
            end
            OPC_LUI, OPC_AUIPC: begin
                imm = {inst[31:12], 12'b0};
            end
            OPC_CSR: begin
                // zimm sits in the rs1 field
                if (inst_funct3(inst) == FNC_CSRRWI) begin
                    imm = {27'b0, inst[19:15]};
                end else begin
                    imm = {20'b0, inst[31:20]};
                end
            end
            default: begin
                imm = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

/* verilog/alu.sv */
`timescale 1ns/100ps
`default_nettype none

module alu import riscv_isa_pkg::*, ex_ctrl_pkg::*; (
    input  logic [XLEN-1:0] a,
    input  logic [XLEN-1:0] b,
    input  alu_op_e         op,
    input  logic            brun,
    output logic [XLEN-1:0] result,
    output logic            breq,
    output logic            brlt
);

    logic       lt;
    logic [4:0] shamt;

    // brun selects unsigned compare
    assign lt    = brun ? (a < b) : ($signed(a) < $signed(b));
    assign shamt = b[4:0];

    assign breq = a == b;
    assign brlt = lt;

    always_comb begin
        case (op)
            ALU_ADD:      result = a + b;
            ALU_SUB:      result = a - b;
            ALU_AND:      result = a & b;
            ALU_OR:       result = a | b;
            ALU_XOR:      result = a ^ b;
            ALU_SLL:      result = a << shamt;
            ALU_SRL:      result = a >> shamt;
            ALU_SRA:      result = $unsigned($signed(a) >>> shamt);
            ALU_SLT:      result = {{(XLEN - 1){1'b0}}, lt};
            ALU_A_PLUS_4: result = a + 32'd4;
            ALU_BSEL:     result = b;
            default:      result = '0;
        endcase
    end

endmodule

`default_nettype wire

/* verilog/ex_control.sv */
`timescale 1ns/100ps
`default_nettype none

module ex_control import riscv_isa_pkg::*, ex_ctrl_pkg::*; #(
    parameter logic [11:0] CSR_ADDR = 12'h51E
) (
    input  logic [31:0] inst,
    input  logic [31:0] mem_inst,
    input  logic [31:0] wb_inst,
    input  logic        breq,
    input  logic        brlt,
    input  logic        br_taken,
    output logic        brun,
    output fwd_sel_e    fwda,
    output fwd_sel_e    fwdb,
    output a_sel_e      asel,
    output b_sel_e      bsel,
    output csr_src_e    csr_src,
    output logic        csr_en,
    output logic        br_mispred,
    output logic        br_suc,
    output logic        flush,
    output alu_op_e     alusel
);

    opcode_e    opcode;
    logic [2:0] funct3;
    logic [4:0] rs1;
    logic [4:0] rs2;
    logic       has_rs1;
    logic       has_rs2;
    logic       mem_match1;
    logic       mem_match2;
    logic       wb_match1;
    logic       wb_match2;
    logic       br_actual;
    alu_op_e    arith_op;

    assign opcode = inst_opcode(inst);
    assign funct3 = inst_funct3(inst);
    assign rs1    = inst_rs1(inst);
    assign rs2    = inst_rs2(inst);

    assign has_rs1 = opcode == OPC_ARI_RTYPE || opcode == OPC_ARI_ITYPE ||
                     opcode == OPC_BRANCH || opcode == OPC_LOAD ||
                     opcode == OPC_STORE || opcode == OPC_JALR ||
                     (opcode == OPC_CSR && funct3 == FNC_CSRRW);
    assign has_rs2 = opcode == OPC_ARI_RTYPE || opcode == OPC_STORE ||
                     opcode == OPC_BRANCH;

    assign mem_match1 = has_rs1 && writes_rd(mem_inst) && inst_rd(mem_inst) == rs1;
    assign mem_match2 = has_rs2 && writes_rd(mem_inst) && inst_rd(mem_inst) == rs2;
    assign wb_match1  = has_rs1 && writes_rd(wb_inst) && inst_rd(wb_inst) == rs1;
    assign wb_match2  = has_rs2 && writes_rd(wb_inst) && inst_rd(wb_inst) == rs2;

    // Younger producer in MEM wins over WB
    assign fwda = mem_match1 ? FWD_MEM : (wb_match1 ? FWD_WB : FWD_NONE);
    assign fwdb = mem_match2 ? FWD_MEM : (wb_match2 ? FWD_WB : FWD_NONE);

    // Kept apart from the branch logic, the comparator depends on it
    always_comb begin
        brun = 1'b0;
        case (opcode)
            OPC_ARI_RTYPE, OPC_ARI_ITYPE: brun = funct3 == FNC_SLTU;
            OPC_BRANCH: brun = funct3 == FNC_BLTU || funct3 == FNC_BGEU;
            default: brun = 1'b0;
        endcase
    end

    always_comb begin
        case (br_funct3_e'(funct3))
            FNC_BEQ:           br_actual = breq;
            FNC_BNE:           br_actual = !breq;
            FNC_BLT, FNC_BLTU: br_actual = brlt;
            FNC_BGE, FNC_BGEU: br_actual = !brlt;
            default:           br_actual = 1'b0;
        endcase
    end

    // Shared by register and immediate arithmetic
    always_comb begin
        case (funct3_e'(funct3))
            FNC_ADD_SUB: arith_op = (opcode == OPC_ARI_RTYPE && inst[30] == FNC7_SUB_SRA) ?
                                    ALU_SUB : ALU_ADD;
            FNC_SLL:     arith_op = ALU_SLL;
            FNC_SLT:     arith_op = ALU_SLT;
            FNC_SLTU:    arith_op = ALU_SLT;
            FNC_XOR:     arith_op = ALU_XOR;
            FNC_SRL_SRA: arith_op = (inst[30] == FNC7_SUB_SRA) ? ALU_SRA : ALU_SRL;
            FNC_OR:      arith_op = ALU_OR;
            FNC_AND:     arith_op = ALU_AND;
            default:     arith_op = ALU_ADD;
        endcase
    end

    always_comb begin
        asel       = A_REG;
        bsel       = B_REG;
        alusel     = ALU_ADD;
        csr_src    = CSR_RS1;
        csr_en     = 1'b0;
        br_mispred = 1'b0;
        br_suc     = 1'b0;
        flush      = 1'b0;

        case (opcode)
            OPC_ARI_RTYPE: begin
                alusel = arith_op;
            end
            OPC_ARI_ITYPE: begin
                bsel   = B_IMM;
                alusel = arith_op;
            end
            OPC_BRANCH: begin
                asel = A_PC;
                bsel = B_IMM;
                if (br_actual == br_taken) begin
                    br_suc = 1'b1;
                end else begin
                    br_mispred = 1'b1;
                    flush      = 1'b1;
                    // ALU produces the corrected fetch address
                    alusel     = br_actual ? ALU_ADD : ALU_A_PLUS_4;
                end
            end
            OPC_LUI: begin
                bsel   = B_IMM;
                alusel = ALU_BSEL;
            end
            OPC_AUIPC: begin
                asel = A_PC;
                bsel = B_IMM;
            end
            OPC_CSR: begin
                csr_src = (funct3 == FNC_CSRRWI) ? CSR_IMM : CSR_RS1;
                csr_en  = (funct3 == FNC_CSRRW || funct3 == FNC_CSRRWI) &&
                          inst[31:20] == CSR_ADDR;
            end
            default: begin
                alusel = ALU_ADD;
            end
        endcase
    end

endmodule

`default_nettype wire

/* verilog/ex_ctrl_pkg.sv */
`default_nettype none

package ex_ctrl_pkg;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_SLT,
        ALU_A_PLUS_4,
        ALU_BSEL
    } alu_op_e;

    typedef enum logic [1:0] {
        FWD_NONE = 2'd0,
        FWD_MEM  = 2'd1,
        FWD_WB   = 2'd2
    } fwd_sel_e;

    typedef enum logic {
        A_REG = 1'b0,
        A_PC  = 1'b1
    } a_sel_e;

    typedef enum logic {
        B_REG = 1'b0,
        B_IMM = 1'b1
    } b_sel_e;

    typedef enum logic {
        CSR_RS1 = 1'b0,
        CSR_IMM = 1'b1
    } csr_src_e;

endpackage

`default_nettype wire

/* verilog/riscv_isa_pkg.sv */
`default_nettype none

package riscv_isa_pkg;

    localparam int XLEN = 32;

    // ADDI x0, x0, 0
    localparam logic [31:0] NOP_INST = 32'h0000_0013;

    typedef enum logic [6:0] {
        OPC_ARI_RTYPE = 7'b0110011,
        OPC_ARI_ITYPE = 7'b0010011,
        OPC_BRANCH    = 7'b1100011,
        OPC_LUI       = 7'b0110111,
        OPC_AUIPC     = 7'b0010111,
        OPC_CSR       = 7'b1110011,
        OPC_LOAD      = 7'b0000011,
        OPC_STORE     = 7'b0100011,
        OPC_JAL       = 7'b1101111,
        OPC_JALR      = 7'b1100111
    } opcode_e;

    typedef enum logic [2:0] {
        FNC_ADD_SUB = 3'b000,
        FNC_SLL     = 3'b001,
        FNC_SLT     = 3'b010,
        FNC_SLTU    = 3'b011,
        FNC_XOR     = 3'b100,
        FNC_SRL_SRA = 3'b101,
        FNC_OR      = 3'b110,
        FNC_AND     = 3'b111
    } funct3_e;

    typedef enum logic [2:0] {
        FNC_BEQ  = 3'b000,
        FNC_BNE  = 3'b001,
        FNC_BLT  = 3'b100,
        FNC_BGE  = 3'b101,
        FNC_BLTU = 3'b110,
        FNC_BGEU = 3'b111
    } br_funct3_e;

    typedef enum logic [2:0] {
        FNC_CSRRW  = 3'b001,
        FNC_CSRRWI = 3'b101
    } csr_funct3_e;

    // Bit 30 of the instruction
    typedef enum logic {
        FNC7_ADD_SRL = 1'b0,
        FNC7_SUB_SRA = 1'b1
    } funct7_bit_e;

    function automatic opcode_e inst_opcode(input logic [31:0] inst);
        return opcode_e'(inst[6:0]);
    endfunction

    function automatic logic [2:0] inst_funct3(input logic [31:0] inst);
        return inst[14:12];
    endfunction

    function automatic logic [4:0] inst_rd(input logic [31:0] inst);
        return inst[11:7];
    endfunction

    function automatic logic [4:0] inst_rs1(input logic [31:0] inst);
        return inst[19:15];
    endfunction

    function automatic logic [4:0] inst_rs2(input logic [31:0] inst);
        return inst[24:20];
    endfunction

    // Only instructions executed here write rd; branches and CSR ops never do
    function automatic logic writes_rd(input logic [31:0] inst);
        opcode_e opc;
        opc = inst_opcode(inst);
        return (opc == OPC_ARI_RTYPE || opc == OPC_ARI_ITYPE ||
                opc == OPC_LUI || opc == OPC_AUIPC) && inst[11:7] != 5'd0;
    endfunction

endpackage

`default_nettype wire
